/* tcp_server.f */
+incdir+hw
hw/tcp_pkg.sv
hw/rx_segment_latch.sv
hw/conn_fsm.sv
hw/data_scheduler.sv
hw/tx_arbiter.sv
hw/tcp_server.sv
dv/tcp_server_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the TCP server testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tcp_server_tb \
	-f tcp_server.f \
	-o tcp_server_sim

./obj_dir/tcp_server_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* dv/tcp_server_tb.sv */
// Self-checking testbench for the TCP server, drives segments and credits and checks every header
`timescale 1ns/1ns
`include "tcp_defines.svh"

module tcp_server_tb import tcp_pkg::*;
();

	localparam int			TIMEOUT		= 200;
	localparam port_t		PEER_PORT	= 16'hC350;
	localparam port_t		OTHER_PORT	= 16'h0050;
	localparam ip_addr_t	PEER_IP		= 32'hC0A8_0A02;
	localparam mac_addr_t	PEER_MAC	= 48'h02_00_5E_10_20_30;
	localparam tcp_flags_t	SYN_ONLY	= tcp_flags_t'(1 << `FLG_SYN);

	typedef struct packed
	{
		tcp_flags_t	flags;
		seq_t		seq;
		seq_t		ack;
		seg_len_t	len;
		port_t		port;
		ip_addr_t	ip;
		mac_addr_t	mac;
	} hdr_t;

	logic						clk;
	logic						rst_n;
	logic						rx_valid_i;
	mac_addr_t					rx_src_mac_i;
	ip_addr_t					rx_src_ip_i;
	port_t						rx_src_port_i;
	port_t						rx_dst_port_i;
	tcp_flags_t					rx_flags_i;
	seq_t						rx_seq_i;
	seq_t						rx_ack_i;
	seg_len_t					rx_len_i;
	logic						rx_ready_o;
	logic						tx_credit_i;
	logic						tx_start_o;
	tcp_flags_t					tx_flags_o;
	seq_t						tx_seq_o;
	seq_t						tx_ack_o;
	seg_len_t					tx_len_o;
	port_t						tx_dst_port_o;
	ip_addr_t					tx_dst_ip_o;
	mac_addr_t					tx_dst_mac_o;
	mem_mask_t					mem_rdy_i;
	seg_len_t [`MEM_NUM-1:0]	mem_len_i;
	mem_mask_t					mem_sel_o;
	logic						tx_data_done_i;
	logic						established_o;
	logic						listen_o;

	// Connection model
	tcp_state_e	m_state;
	seq_t		m_snd;
	seq_t		m_rcv;
	port_t		m_peer;
	int			m_last;

	integer		seed;
	hdr_t		exp_q[$];
	int			tx_count;
	bit			hold_credits;

	tcp_server dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERR %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// ------------------------------------------------------------------------
	// Reference rules of the passive-open connection
	// ------------------------------------------------------------------------
	function automatic bit predict_reply(input tcp_state_e st, input seq_t snd, input seq_t rcv,
		input port_t peer, input port_t sport, input port_t dport, input tcp_flags_t flg,
		input seq_t sq, input seq_t ak, input seg_len_t ln, output tcp_state_e st_n,
		output seq_t snd_n, output seq_t rcv_n, output bit capture, output hdr_t hdr);
		bit reply;
		reply	= 1'b0;
		st_n	= st;
		snd_n	= snd;
		rcv_n	= rcv;
		capture	= 1'b0;
		hdr		= '0;
		if (dport == `LOCAL_PORT && st == ST_LISTEN && !flg[`FLG_RST])
		begin
			if (flg[`FLG_SYN] && !flg[`FLG_ACK])
			begin
				st_n		= ST_SYN_RCVD;
				capture		= 1'b1;
				reply		= 1'b1;
				hdr.flags	= `FLAGS_SYNACK;
				hdr.seq		= `ISS;
				hdr.ack		= sq + 32'd1;
			end
			else if (flg[`FLG_ACK])
			begin
				reply		= 1'b1;
				hdr.flags	= `FLAGS_RST;
				hdr.seq		= ak;
			end
		end
		else if (dport == `LOCAL_PORT && st != ST_LISTEN && sport == peer)
		begin
			if (flg[`FLG_RST])
				st_n = ST_LISTEN;
			else if (st == ST_SYN_RCVD && flg[`FLG_ACK])
			begin
				st_n	= ST_ESTABLISHED;
				snd_n	= `ISS + 32'd1;
				rcv_n	= sq + seq_t'(ln);
			end
			else if (st == ST_ESTABLISHED && flg[`FLG_FIN])
			begin
				// CLOSE_WAIT answers on its own, so the model skips it
				st_n		= ST_LAST_ACK;
				rcv_n		= sq + 32'd1;
				reply		= 1'b1;
				hdr.flags	= `FLAGS_FINACK;
				hdr.seq		= snd;
				hdr.ack		= sq + 32'd1;
			end
			else if (st == ST_ESTABLISHED && ln != '0)
			begin
				rcv_n		= sq + seq_t'(ln);
				reply		= 1'b1;
				hdr.flags	= `FLAGS_ACK;
				hdr.seq		= snd;
				hdr.ack		= sq + seq_t'(ln);
			end
			else if (st == ST_LAST_ACK && flg[`FLG_ACK])
				st_n = ST_LISTEN;
		end
		return reply;
	endfunction

	// Next ready buffer after the last one served
	function automatic int next_ready(input int last, input mem_mask_t rdy);
		int k;
		for (int i = 1; i <= `MEM_NUM; i++)
		begin
			k = (last + i) % `MEM_NUM;
			if (rdy[k])
				return k;
		end
		return -1;
	endfunction

	task automatic send_seg(input port_t sport, input port_t dport, input tcp_flags_t flg,
		input seq_t sq, input seq_t ak, input seg_len_t ln);
		hdr_t		h;
		tcp_state_e	st_n;
		seq_t		snd_n;
		seq_t		rcv_n;
		bit			cap;
		bit			rep;
		int			t;
		rep = predict_reply(m_state, m_snd, m_rcv, m_peer, sport, dport, flg, sq, ak, ln,
			st_n, snd_n, rcv_n, cap, h);
		if (cap)
			m_peer = sport;
		if (rep)
		begin
			h.port	= m_peer;
			h.ip	= PEER_IP;
			h.mac	= PEER_MAC;
			exp_q.push_back(h);
		end
		m_state	= st_n;
		m_snd	= snd_n;
		m_rcv	= rcv_n;
		@(negedge clk);
		rx_valid_i		= 1'b1;
		rx_src_port_i	= sport;
		rx_dst_port_i	= dport;
		rx_flags_i		= flg;
		rx_seq_i		= sq;
		rx_ack_i		= ak;
		rx_len_i		= ln;
		#1;
		t = 0;
		while (!rx_ready_o)
		begin
			t++;
			if (t > TIMEOUT)
			begin
				$display("Receive handshake timed out, rx_ready_o never rose");
				abort_run();
			end
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		rx_valid_i = 1'b0;
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while (exp_q.size() != 0)
		begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
			begin
				$display("Expected transmit header never appeared");
				abort_run();
			end
		end
		// Quiet window where any extra header would show up
		repeat (6) @(negedge clk);
	endtask

	task automatic wait_high(input string name, ref logic sig);
		int t;
		t = 0;
		while (sig !== 1'b1)
		begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
			begin
				$display("Timed out waiting for %s", name);
				abort_run();
			end
		end
	endtask

	// Transmitter model returns one credit per header unless held
	initial
	begin
		int owed;
		owed = 0;
		tx_credit_i = 1'b0;
		forever
		begin
			@(negedge clk);
			if (rst_n && tx_start_o)
				owed++;
			if (rst_n && !hold_credits && owed > 0)
			begin
				tx_credit_i = 1'b1;
				owed--;
			end
			else
				tx_credit_i = 1'b0;
		end
	end

	// Every header on the bus against the expected queue
	initial
	begin
		hdr_t e;
		tx_count = 0;
		forever
		begin
			@(negedge clk);
			if (rst_n && tx_start_o)
			begin
				tx_count++;
				assert (exp_q.size() != 0)
				else
				begin
					$display("tx_start_o pulsed while no header was expected");
					abort_run();
				end
				e = exp_q.pop_front();
				check_val("tx_flags_o", tx_flags_o, e.flags);
				check_val("tx_seq_o", tx_seq_o, e.seq);
				check_val("tx_ack_o", tx_ack_o, e.ack);
				check_val("tx_len_o", tx_len_o, e.len);
				check_val("tx_dst_port_o", tx_dst_port_o, e.port);
				check_val("tx_dst_ip_o", tx_dst_ip_o, e.ip);
				check_val("tx_dst_mac_o", tx_dst_mac_o, e.mac);
			end
		end
	end

	initial
	begin
		seq_t		peer_nxt;
		seg_len_t	ln;
		hdr_t		h;
		int			idx;
		int			base;
		int			t;
		mem_mask_t	rdy_set;
		seed			= 19668;
		rst_n			= 1'b0;
		rx_valid_i		= 1'b0;
		rx_src_mac_i	= PEER_MAC;
		rx_src_ip_i		= PEER_IP;
		rx_src_port_i	= '0;
		rx_dst_port_i	= '0;
		rx_flags_i		= '0;
		rx_seq_i		= '0;
		rx_ack_i		= '0;
		rx_len_i		= '0;
		mem_rdy_i		= '0;
		mem_len_i		= '0;
		tx_data_done_i	= 1'b0;
		hold_credits	= 1'b0;
		m_state			= ST_LISTEN;
		m_snd			= `ISS;
		m_rcv			= '0;
		m_peer			= '0;
		m_last			= `MEM_NUM - 1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_val("listen_o", listen_o, 1);
		check_val("tx_start_o", tx_start_o, 0);
		check_val("mem_sel_o", mem_sel_o, 0);
		check_val("rx_ready_o", rx_ready_o, 0);

		// --------------------------------------------------------------------
		// Three-way handshake, then data in both directions
		// --------------------------------------------------------------------
		peer_nxt = $random(seed);
		send_seg(PEER_PORT, `LOCAL_PORT, SYN_ONLY, peer_nxt, '0, '0);
		peer_nxt = peer_nxt + 32'd1;
		wait_drained();
		send_seg(PEER_PORT, `LOCAL_PORT, `FLAGS_ACK, peer_nxt, `ISS + 32'd1, '0);
		wait_high("established_o", established_o);

		ln = seg_len_t'(($random(seed) & 32'h3FF) + 1);
		send_seg(PEER_PORT, `LOCAL_PORT, `FLAGS_PSHACK, peer_nxt, m_snd, ln);
		peer_nxt = peer_nxt + seq_t'(ln);
		wait_drained();
		// Dropped by the port filter
		send_seg(PEER_PORT, OTHER_PORT, `FLAGS_PSHACK, peer_nxt, m_snd, 16'd20);
		wait_drained();

		for (int i = 0; i < `MEM_NUM; i++)
			mem_len_i[i] = seg_len_t'(($random(seed) & 32'h3FF) + 64);
		rdy_set = 4'b1011;
		for (int n = 0; n < 6; n++)
		begin
			idx		= next_ready(m_last, rdy_set);
			h		= '0;
			h.flags	= `FLAGS_PSHACK;
			h.seq	= m_snd;
			h.ack	= m_rcv;
			h.len	= mem_len_i[idx];
			h.port	= m_peer;
			h.ip	= PEER_IP;
			h.mac	= PEER_MAC;
			exp_q.push_back(h);
			mem_rdy_i = rdy_set;
			t = 0;
			while (mem_sel_o == '0)
			begin
				@(negedge clk);
				t++;
				if (t > TIMEOUT)
				begin
					$display("Timed out waiting for a buffer selection");
					abort_run();
				end
			end
			check_val("mem_sel_o", mem_sel_o, 64'(1) << idx);
			@(negedge clk);
			tx_data_done_i = 1'b1;
			if (n == 5)
				mem_rdy_i = '0;
			@(negedge clk);
			tx_data_done_i = 1'b0;
			m_snd = m_snd + seq_t'(mem_len_i[idx]);
			m_last = idx;
		end
		wait_drained();

		// --------------------------------------------------------------------
		// Credits held back, then released
		// --------------------------------------------------------------------
		hold_credits = 1'b1;
		base = tx_count;
		for (int n = 0; n < 4; n++)
		begin
			ln = seg_len_t'(($random(seed) & 32'hFF) + 1);
			send_seg(PEER_PORT, `LOCAL_PORT, `FLAGS_PSHACK, peer_nxt, m_snd, ln);
			peer_nxt = peer_nxt + seq_t'(ln);
		end
		repeat (20) @(negedge clk);
		assert (tx_count - base <= `TX_CREDITS)
		else
		begin
			$display("More headers were sent than the transmitter had credits for");
			abort_run();
		end
		hold_credits = 1'b0;
		wait_drained();

		// --------------------------------------------------------------------
		// Passive close and a stray ACK in LISTEN
		// --------------------------------------------------------------------
		send_seg(PEER_PORT, `LOCAL_PORT, `FLAGS_FINACK, peer_nxt, m_snd, '0);
		peer_nxt = peer_nxt + 32'd1;
		wait_drained();
		check_val("listen_o", listen_o, 0);
		send_seg(PEER_PORT, `LOCAL_PORT, `FLAGS_ACK, peer_nxt, m_snd + 32'd1, '0);
		wait_high("listen_o", listen_o);

		send_seg(PEER_PORT, `LOCAL_PORT, `FLAGS_ACK, $random(seed), $random(seed), '0);
		wait_drained();

		$display("Test OK");
		$finish;
	end

endmodule

/* hw/tcp_server.sv */
// Top level of the passive-open TCP server, connects receive latch, FSM, scheduler and arbiter
`timescale 1ns/1ns
`include "tcp_defines.svh"

module tcp_server import tcp_pkg::*;
(
	input	logic						clk,
	input	logic						rst_n,

	// Decoded receive headers
	input	logic						rx_valid_i,
	input	mac_addr_t					rx_src_mac_i,
	input	ip_addr_t					rx_src_ip_i,
	input	port_t						rx_src_port_i,
	input	port_t						rx_dst_port_i,
	input	tcp_flags_t					rx_flags_i,
	input	seq_t						rx_seq_i,
	input	seq_t						rx_ack_i,
	input	seg_len_t					rx_len_i,
	output	logic						rx_ready_o,

	// Transmit header bus
	input	logic						tx_credit_i,
	output	logic						tx_start_o,
	output	tcp_flags_t					tx_flags_o,
	output	seq_t						tx_seq_o,
	output	seq_t						tx_ack_o,
	output	seg_len_t					tx_len_o,
	output	port_t						tx_dst_port_o,
	output	ip_addr_t					tx_dst_ip_o,
	output	mac_addr_t					tx_dst_mac_o,

	// Transmit memory buffers
	input	mem_mask_t					mem_rdy_i,
	input	seg_len_t [`MEM_NUM-1:0]	mem_len_i,
	output	mem_mask_t					mem_sel_o,
	input	logic						tx_data_done_i,

	output	logic						established_o,
	output	logic						listen_o
);

	logic		seg_valid;
	logic		seg_take;
	mac_addr_t	seg_src_mac;
	ip_addr_t	seg_src_ip;
	port_t		seg_src_port;
	tcp_flags_t	seg_flags;
	seq_t		seg_seq;
	seq_t		seg_ack;
	seg_len_t	seg_len;

	logic		ctrl_req;
	logic		ctrl_gnt;
	tcp_flags_t	ctrl_flags;
	seq_t		ctrl_seq;
	seq_t		ctrl_ack;
	logic		data_req;
	logic		data_gnt;
	seg_len_t	data_len;
	logic		data_sent;
	seg_len_t	data_sent_len;

	seq_t		snd_nxt;
	seq_t		rcv_nxt;
	port_t		peer_port;
	ip_addr_t	peer_ip;
	mac_addr_t	peer_mac;

	rx_segment_latch u_rx_latch (
		.clk			(clk),
		.rst_n			(rst_n),
		.rx_valid_i		(rx_valid_i),
		.rx_src_mac_i	(rx_src_mac_i),
		.rx_src_ip_i	(rx_src_ip_i),
		.rx_src_port_i	(rx_src_port_i),
		.rx_dst_port_i	(rx_dst_port_i),
		.rx_flags_i		(rx_flags_i),
		.rx_seq_i		(rx_seq_i),
		.rx_ack_i		(rx_ack_i),
		.rx_len_i		(rx_len_i),
		.rx_ready_o		(rx_ready_o),
		.seg_take_i		(seg_take),
		.seg_valid_o	(seg_valid),
		.seg_src_mac_o	(seg_src_mac),
		.seg_src_ip_o	(seg_src_ip),
		.seg_src_port_o	(seg_src_port),
		.seg_flags_o	(seg_flags),
		.seg_seq_o		(seg_seq),
		.seg_ack_o		(seg_ack),
		.seg_len_o		(seg_len)
	);

	conn_fsm u_conn_fsm (
		.clk				(clk),
		.rst_n				(rst_n),
		.seg_valid_i		(seg_valid),
		.seg_src_mac_i		(seg_src_mac),
		.seg_src_ip_i		(seg_src_ip),
		.seg_src_port_i		(seg_src_port),
		.seg_flags_i		(seg_flags),
		.seg_seq_i			(seg_seq),
		.seg_ack_i			(seg_ack),
		.seg_len_i			(seg_len),
		.seg_take_o			(seg_take),
		.ctrl_gnt_i			(ctrl_gnt),
		.ctrl_req_o			(ctrl_req),
		.ctrl_flags_o		(ctrl_flags),
		.ctrl_seq_o			(ctrl_seq),
		.ctrl_ack_o			(ctrl_ack),
		.data_sent_i		(data_sent),
		.data_sent_len_i	(data_sent_len),
		.snd_nxt_o			(snd_nxt),
		.rcv_nxt_o			(rcv_nxt),
		.peer_port_o		(peer_port),
		.peer_ip_o			(peer_ip),
		.peer_mac_o			(peer_mac),
		.established_o		(established_o),
		.listen_o			(listen_o)
	);

	data_scheduler u_data_sched (
		.clk				(clk),
		.rst_n				(rst_n),
		.established_i		(established_o),
		.mem_rdy_i			(mem_rdy_i),
		.mem_len_i			(mem_len_i),
		.data_gnt_i			(data_gnt),
		.data_req_o			(data_req),
		.data_len_o			(data_len),
		.mem_sel_o			(mem_sel_o),
		.tx_data_done_i		(tx_data_done_i),
		.data_sent_o		(data_sent),
		.data_sent_len_o	(data_sent_len)
	);

	tx_arbiter u_tx_arb (
		.clk			(clk),
		.rst_n			(rst_n),
		.tx_credit_i	(tx_credit_i),
		.ctrl_req_i		(ctrl_req),
		.ctrl_flags_i	(ctrl_flags),
		.ctrl_seq_i		(ctrl_seq),
		.ctrl_ack_i		(ctrl_ack),
		.ctrl_gnt_o		(ctrl_gnt),
		.data_req_i		(data_req),
		.data_len_i		(data_len),
		.data_gnt_o		(data_gnt),
		.snd_nxt_i		(snd_nxt),
		.rcv_nxt_i		(rcv_nxt),
		.peer_port_i	(peer_port),
		.peer_ip_i		(peer_ip),
		.peer_mac_i		(peer_mac),
		.tx_start_o		(tx_start_o),
		.tx_flags_o		(tx_flags_o),
		.tx_seq_o		(tx_seq_o),
		.tx_ack_o		(tx_ack_o),
		.tx_len_o		(tx_len_o),
		.tx_dst_port_o	(tx_dst_port_o),
		.tx_dst_ip_o	(tx_dst_ip_o),
		.tx_dst_mac_o	(tx_dst_mac_o)
	);

endmodule

/* hw/tx_arbiter.sv */
// Credit-gated arbiter for the transmit header bus, control replies win over data segments
`timescale 1ns/1ns
`include "tcp_defines.svh"

module tx_arbiter import tcp_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,

	input	logic		tx_credit_i,

	input	logic		ctrl_req_i,
	input	tcp_flags_t	ctrl_flags_i,
	input	seq_t		ctrl_seq_i,
	input	seq_t		ctrl_ack_i,
	output	logic		ctrl_gnt_o,

	input	logic		data_req_i,
	input	seg_len_t	data_len_i,
	output	logic		data_gnt_o,

	input	seq_t		snd_nxt_i,
	input	seq_t		rcv_nxt_i,
	input	port_t		peer_port_i,
	input	ip_addr_t	peer_ip_i,
	input	mac_addr_t	peer_mac_i,

	output	logic		tx_start_o,
	output	tcp_flags_t	tx_flags_o,
	output	seq_t		tx_seq_o,
	output	seq_t		tx_ack_o,
	output	seg_len_t	tx_len_o,
	output	port_t		tx_dst_port_o,
	output	ip_addr_t	tx_dst_ip_o,
	output	mac_addr_t	tx_dst_mac_o
);

	localparam int					CRED_W		= $clog2(`TX_CREDITS + 1);
	localparam logic [CRED_W-1:0]	CRED_MAX	= CRED_W'(`TX_CREDITS);

	logic [CRED_W-1:0]	credit_cnt;
	logic				credit_ok;
	logic				any_gnt;

	assign credit_ok	= (credit_cnt != '0);
	assign ctrl_gnt_o	= ctrl_req_i && credit_ok;
	assign data_gnt_o	= data_req_i && !ctrl_req_i && credit_ok;
	assign any_gnt		= ctrl_gnt_o || data_gnt_o;

	// Grant and returned credit in the same cycle cancel out
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			credit_cnt	<= CRED_MAX;
			tx_start_o	<= 1'b0;
		end
		else
		begin
			tx_start_o <= any_gnt;
			if (any_gnt && !tx_credit_i)
				credit_cnt <= credit_cnt - 1'b1;
			else if (!any_gnt && tx_credit_i && (credit_cnt != CRED_MAX))
				credit_cnt <= credit_cnt + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Header of the winning requester
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (any_gnt)
		begin
			tx_flags_o		<= ctrl_gnt_o ? ctrl_flags_i : `FLAGS_PSHACK;
			tx_seq_o		<= ctrl_gnt_o ? ctrl_seq_i : snd_nxt_i;
			tx_ack_o		<= ctrl_gnt_o ? ctrl_ack_i : rcv_nxt_i;
			tx_len_o		<= ctrl_gnt_o ? '0 : data_len_i;
			tx_dst_port_o	<= peer_port_i;
			tx_dst_ip_o		<= peer_ip_i;
			tx_dst_mac_o	<= peer_mac_i;
		end
	end

	// Transmitter must never return more credits than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		tx_credit_i && !any_gnt |-> credit_cnt != CRED_MAX)
		else $error("credit returned while the count is at TX_CREDITS");

endmodule

/* hw/data_scheduler.sv */
// Round-robin picker over the transmit memory buffers, requests one data segment at a time
`timescale 1ns/1ns
`include "tcp_defines.svh"

module data_scheduler import tcp_pkg::*;
(
	input	logic						clk,
	input	logic						rst_n,

	input	logic						established_i,
	input	mem_mask_t					mem_rdy_i,
	input	seg_len_t [`MEM_NUM-1:0]	mem_len_i,

	input	logic						data_gnt_i,
	output	logic						data_req_o,
	output	seg_len_t					data_len_o,

	output	mem_mask_t					mem_sel_o,
	input	logic						tx_data_done_i,
	output	logic						data_sent_o,
	output	seg_len_t					data_sent_len_o
);

	localparam int IDX_W = (`MEM_NUM > 1) ? $clog2(`MEM_NUM) : 1;

	typedef enum logic [1:0] {DS_IDLE, DS_REQ, DS_SEND} ds_state_e;

	ds_state_e			state;
	logic [IDX_W-1:0]	last_idx;
	logic [IDX_W-1:0]	cur_idx;
	logic [IDX_W-1:0]	pick_idx;

	// Nearest ready buffer after the last one served, the last one itself comes last
	always_comb
	begin
		int k;
		pick_idx = last_idx;
		for (int i = `MEM_NUM; i >= 1; i--)
		begin
			k = (int'(last_idx) + i) % `MEM_NUM;
			if (mem_rdy_i[k])
				pick_idx = IDX_W'(k);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state		<= DS_IDLE;
			last_idx	<= IDX_W'(`MEM_NUM - 1);
		end
		else
		begin
			case (state)
				DS_IDLE:
					if (established_i && (mem_rdy_i != '0))
						state <= DS_REQ;
				DS_REQ:
					if (data_gnt_i)
						state <= DS_SEND;
					else if (!established_i)
						state <= DS_IDLE;
				DS_SEND:
					if (tx_data_done_i)
					begin
						state		<= DS_IDLE;
						last_idx	<= cur_idx;
					end
				default:
					state <= DS_IDLE;
			endcase
		end
	end

	// Selection and length are frozen once the request is raised
	always_ff @(posedge clk)
	begin
		if (state == DS_IDLE)
		begin
			cur_idx		<= pick_idx;
			data_len_o	<= mem_len_i[pick_idx];
		end
	end

	assign data_req_o		= (state == DS_REQ);
	assign mem_sel_o		= (state == DS_SEND) ? mem_mask_t'(1) << cur_idx : '0;
	assign data_sent_o		= (state == DS_SEND) && tx_data_done_i;
	assign data_sent_len_o	= data_len_o;

endmodule

/* hw/conn_fsm.sv */
// Connection FSM of the passive-open server, tracks sequence numbers and requests control replies
`timescale 1ns/1ns
`include "tcp_defines.svh"

module conn_fsm import tcp_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,

	input	logic		seg_valid_i,
	input	mac_addr_t	seg_src_mac_i,
	input	ip_addr_t	seg_src_ip_i,
	input	port_t		seg_src_port_i,
	input	tcp_flags_t	seg_flags_i,
	input	seq_t		seg_seq_i,
	input	seq_t		seg_ack_i,
	input	seg_len_t	seg_len_i,
	output	logic		seg_take_o,

	input	logic		ctrl_gnt_i,
	output	logic		ctrl_req_o,
	output	tcp_flags_t	ctrl_flags_o,
	output	seq_t		ctrl_seq_o,
	output	seq_t		ctrl_ack_o,

	input	logic		data_sent_i,
	input	seg_len_t	data_sent_len_i,

	output	seq_t		snd_nxt_o,
	output	seq_t		rcv_nxt_o,
	output	port_t		peer_port_o,
	output	ip_addr_t	peer_ip_o,
	output	mac_addr_t	peer_mac_o,
	output	logic		established_o,
	output	logic		listen_o
);

	tcp_state_e	state;
	tcp_state_e	state_nxt;
	logic		take;
	logic		peer_hit;
	logic		req_set;
	logic		rcv_set;
	logic		peer_cap;
	tcp_flags_t	req_flags;
	seq_t		req_seq;
	seq_t		req_ack;
	seq_t		rcv_val;

	// No segment is consumed while a reply waits or in the transient states
	assign take = seg_valid_i && !ctrl_req_o
		&& (state != ST_CLOSE_WAIT) && (state != ST_CLOSED);
	assign seg_take_o = take;
	assign peer_hit = (seg_src_port_i == peer_port_o);

	// ------------------------------------------------------------------------
	// Next state and reply decode
	// ------------------------------------------------------------------------
	always_comb
	begin
		state_nxt	= state;
		req_set		= 1'b0;
		req_flags	= `FLAGS_ACK;
		req_seq		= snd_nxt_o;
		req_ack		= rcv_nxt_o;
		rcv_set		= 1'b0;
		rcv_val		= rcv_nxt_o;
		peer_cap	= 1'b0;
		case (state)
			ST_LISTEN:
				if (take && !seg_flags_i[`FLG_RST])
				begin
					if (seg_flags_i[`FLG_SYN] && !seg_flags_i[`FLG_ACK])
					begin
						state_nxt	= ST_SYN_RCVD;
						peer_cap	= 1'b1;
						req_set		= 1'b1;
						req_flags	= `FLAGS_SYNACK;
						req_seq		= `ISS;
						req_ack		= seg_seq_i + 32'd1;
					end
					else if (seg_flags_i[`FLG_ACK])
					begin
						// Stray ACK gets a reset carrying its ack number
						req_set		= 1'b1;
						req_flags	= `FLAGS_RST;
						req_seq		= seg_ack_i;
						req_ack		= '0;
					end
				end
			ST_SYN_RCVD, ST_LAST_ACK:
				if (take && peer_hit)
				begin
					if (seg_flags_i[`FLG_RST])
						state_nxt = ST_LISTEN;
					else if (seg_flags_i[`FLG_ACK] && (state == ST_SYN_RCVD))
					begin
						state_nxt	= ST_ESTABLISHED;
						rcv_set		= 1'b1;
						rcv_val		= seg_seq_i + seg_len_i;
					end
					else if (seg_flags_i[`FLG_ACK])
						state_nxt = ST_CLOSED;
				end
			ST_ESTABLISHED:
				if (take && peer_hit)
				begin
					if (seg_flags_i[`FLG_RST])
						state_nxt = ST_LISTEN;
					else if (seg_flags_i[`FLG_FIN])
					begin
						state_nxt	= ST_CLOSE_WAIT;
						rcv_set		= 1'b1;
						rcv_val		= seg_seq_i + 32'd1;
					end
					else if (seg_len_i != '0)
					begin
						rcv_set		= 1'b1;
						rcv_val		= seg_seq_i + seg_len_i;
						req_set		= 1'b1;
						req_ack		= seg_seq_i + seg_len_i;
					end
				end
			ST_CLOSE_WAIT:
				if (!ctrl_req_o)
				begin
					state_nxt	= ST_LAST_ACK;
					req_set		= 1'b1;
					req_flags	= `FLAGS_FINACK;
				end
			default:
				state_nxt = ST_LISTEN;
		endcase
	end

	// ------------------------------------------------------------------------
	// State, request and sequence registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state		<= ST_LISTEN;
			ctrl_req_o	<= 1'b0;
			snd_nxt_o	<= `ISS;
			rcv_nxt_o	<= '0;
		end
		else
		begin
			state <= state_nxt;
			if (req_set)
				ctrl_req_o <= 1'b1;
			else if (ctrl_gnt_i)
				ctrl_req_o <= 1'b0;
			if ((state == ST_SYN_RCVD) && (state_nxt == ST_ESTABLISHED))
				snd_nxt_o <= `ISS + 32'd1;
			else if (data_sent_i)
				snd_nxt_o <= snd_nxt_o + data_sent_len_i;
			if (rcv_set)
				rcv_nxt_o <= rcv_val;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_set)
		begin
			ctrl_flags_o	<= req_flags;
			ctrl_seq_o		<= req_seq;
			ctrl_ack_o		<= req_ack;
		end
		if (peer_cap)
		begin
			peer_port_o	<= seg_src_port_i;
			peer_ip_o	<= seg_src_ip_i;
			peer_mac_o	<= seg_src_mac_i;
		end
	end

	assign established_o	= (state == ST_ESTABLISHED);
	assign listen_o			= (state == ST_LISTEN);

	// Pending reply must not change before the arbiter takes it
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl_req_o && !ctrl_gnt_i |=> ctrl_req_o && $stable(ctrl_flags_o)
			&& $stable(ctrl_seq_o) && $stable(ctrl_ack_o))
		else $error("control request changed before grant");

endmodule

/* hw/rx_segment_latch.sv */
// One-entry receive header buffer, sits between the segment decoder and the connection FSM
`timescale 1ns/1ns
`include "tcp_defines.svh"

module rx_segment_latch import tcp_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,

	input	logic		rx_valid_i,
	input	mac_addr_t	rx_src_mac_i,
	input	ip_addr_t	rx_src_ip_i,
	input	port_t		rx_src_port_i,
	input	port_t		rx_dst_port_i,
	input	tcp_flags_t	rx_flags_i,
	input	seq_t		rx_seq_i,
	input	seq_t		rx_ack_i,
	input	seg_len_t	rx_len_i,
	output	logic		rx_ready_o,

	input	logic		seg_take_i,
	output	logic		seg_valid_o,
	output	mac_addr_t	seg_src_mac_o,
	output	ip_addr_t	seg_src_ip_o,
	output	port_t		seg_src_port_o,
	output	tcp_flags_t	seg_flags_o,
	output	seq_t		seg_seq_o,
	output	seq_t		seg_ack_o,
	output	seg_len_t	seg_len_o
);

	logic	full;
	logic	rx_xfer;

	assign rx_ready_o = !full && rx_valid_i;
	assign rx_xfer = rx_ready_o;

	// Entry fills only for our port, other segments are swallowed
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			full <= 1'b0;
		else if (rx_xfer && (rx_dst_port_i == `LOCAL_PORT))
			full <= 1'b1;
		else if (seg_take_i)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rx_xfer)
		begin
			seg_src_mac_o	<= rx_src_mac_i;
			seg_src_ip_o	<= rx_src_ip_i;
			seg_src_port_o	<= rx_src_port_i;
			seg_flags_o		<= rx_flags_i;
			seg_seq_o		<= rx_seq_i;
			seg_ack_o		<= rx_ack_i;
			seg_len_o		<= rx_len_i;
		end
	end

	assign seg_valid_o = full;

	// FSM may only consume a segment that is actually held
	a_take_when_valid: assert property (@(posedge clk) disable iff (!rst_n)
		seg_take_i |-> seg_valid_o)
		else $error("seg_take_i without a held segment");

endmodule

/* hw/tcp_pkg.sv */
// Types shared by the TCP server modules, imported by every RTL block and the testbench
`include "tcp_defines.svh"

package tcp_pkg;

	// Header fields
	typedef logic [`SEQ_W-1:0]		seq_t;
	typedef logic [`PORT_W-1:0]		port_t;
	typedef logic [`IP_W-1:0]		ip_addr_t;
	typedef logic [`MAC_W-1:0]		mac_addr_t;
	typedef logic [`LEN_W-1:0]		seg_len_t;
	typedef logic [`FLAGS_W-1:0]	tcp_flags_t;

	// One bit per transmit memory buffer
	typedef logic [`MEM_NUM-1:0]	mem_mask_t;

	// Passive-open connection states
	typedef enum logic [2:0]
	{
		ST_LISTEN,
		ST_SYN_RCVD,
		ST_ESTABLISHED,
		ST_CLOSE_WAIT,
		ST_LAST_ACK,
		ST_CLOSED
	} tcp_state_e;

endpackage

/* hw/tcp_defines.svh */
// Shared widths, flag codes and constants of the TCP server, included by the package and testbench
`ifndef TCP_DEFINES_SVH
`define TCP_DEFINES_SVH

// Field widths
`define SEQ_W		32
`define PORT_W		16
`define IP_W		32
`define MAC_W		48
`define LEN_W		16
`define FLAGS_W		6

// Connection constants
`define MEM_NUM		4
`define LOCAL_PORT	16'h1F90
`define ISS			32'h0000_0000
`define TX_CREDITS	2

// Flag bit positions
`define FLG_FIN		0
`define FLG_SYN		1
`define FLG_RST		2
`define FLG_PSH		3
`define FLG_ACK		4

// Composite flag codes for outgoing segments
`define FLAGS_SYNACK	6'h12
`define FLAGS_ACK		6'h10
`define FLAGS_FINACK	6'h11
`define FLAGS_RST		6'h04
`define FLAGS_PSHACK	6'h18

`endif
